// File: uart_cmd.f
verilog/uart_cmd_pkg.sv
verilog/baud_timer.sv
verilog/uart_tx_frame.sv
verilog/uart_rx_frame.sv
verilog/cmd_fsm.sv
verilog/uart_cmd_bridge.sv
testbench/tb_uart_cmd_bridge.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --timescale 1ns/1ns \
  --top-module tb_uart_cmd_bridge \
  -f uart_cmd.f \
  --Mdir obj_dir -o sim_uart_cmd

./obj_dir/sim_uart_cmd

// File: testbench/tb_uart_cmd_bridge.sv
`timescale 1ns/1ns

module tb_uart_cmd_bridge;

  localparam int n_random   = 40;
  localparam int n_cmds     = 6 + n_random;
  localparam int clk_period = 40;
  localparam int tail_bits  = 2 * uart_cmd_pkg::frame_bits;
  localparam longint timeout_ns =
    longint'(n_cmds * 40 + tail_bits) * uart_cmd_pkg::clks_per_bit * clk_period
    + 16 * clk_period;

  logic                       clk;
  logic                       rst_n;
  uart_cmd_pkg::cmd_t         cmd_in;
  logic                       cmd_vld;
  logic                       rx;
  logic                       tx;
  logic                       cmd_rdy;
  logic                       read_rdy;
  uart_cmd_pkg::read_result_t read_data;

  // remote device memory, indexed by the 7-bit address
  uart_cmd_pkg::byte_t model_mem [128];
  uart_cmd_pkg::byte_t exp_tx_q [$];
  logic                corrupt_q [$];
  // corrupt flag in bit 7, address below
  logic [7:0]          read_q [$];

  uart_cmd_bridge i_uart_cmd_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_byte(input uart_cmd_pkg::byte_t got, input uart_cmd_pkg::byte_t exp,
                            input string what);
    if (got !== exp) begin
      $display("error %0t: %s got %02h expected %02h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_parity(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("error %0t: %s got %b expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("error %0t: %s got %b expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_read(input uart_cmd_pkg::read_result_t got,
                            input uart_cmd_pkg::read_result_t exp);
    if (got !== exp) begin
      $display("error %0t: read_data got %03h expected %03h", $time, got, exp);
      stop_run();
    end
  endtask

  // stored byte, error flag only when a bad reply is checked
  function automatic uart_cmd_pkg::read_result_t expected_read(
    input logic [6:0] addr, input uart_cmd_pkg::byte_t mem [128], input logic corrupt);
    return {corrupt && uart_cmd_pkg::parity_check, mem[addr]};
  endfunction

  // decode one tx frame, sampling each bit at its centre
  task automatic receive_frame(output uart_cmd_pkg::byte_t data);
    logic [uart_cmd_pkg::frame_bits-1:0] bits;
    @(negedge clk);
    while (tx !== 1'b0) begin
      @(negedge clk);
    end
    repeat (uart_cmd_pkg::clks_per_bit / 2) @(negedge clk);
    bits[0] = tx;
    for (int i = 1; i < uart_cmd_pkg::frame_bits; i++) begin
      repeat (uart_cmd_pkg::clks_per_bit) @(negedge clk);
      bits[i] = tx;
      check_level(cmd_rdy, 1'b0, "cmd_rdy during frame");
    end
    // last cycle of the stop bit
    repeat (uart_cmd_pkg::clks_per_bit - uart_cmd_pkg::clks_per_bit / 2 - 1) @(negedge clk);
    check_level(tx, 1'b1, "tx at end of stop bit");
    check_level(cmd_rdy, 1'b0, "cmd_rdy at end of stop bit");
    data = bits[8:1];
    check_level(bits[0], 1'b0, "tx start bit");
    check_level(bits[uart_cmd_pkg::frame_bits-1], 1'b1, "tx stop bit");
    check_parity(bits[uart_cmd_pkg::frame_bits-2], ($countones(data) % 2) == 0,
                 "tx parity bit");
    if (exp_tx_q.size() == 0) begin
      $display("%0t: a frame appeared on tx with no command pending", $time);
      stop_run();
    end else begin
      check_byte(data, exp_tx_q.pop_front(), "tx byte");
    end
  endtask

  task automatic send_reply(input uart_cmd_pkg::byte_t data, input logic corrupt);
    logic [uart_cmd_pkg::frame_bits-1:0] bits;
    bits = {1'b1, (~^data) ^ corrupt, data, 1'b0};
    for (int i = 0; i < uart_cmd_pkg::frame_bits - 1; i++) begin
      rx = bits[i];
      repeat (uart_cmd_pkg::clks_per_bit) @(negedge clk);
    end
    // stop bit stays on the line as idle
    rx = bits[uart_cmd_pkg::frame_bits-1];
  endtask

  task automatic issue_cmd(input uart_cmd_pkg::cmd_t cmd, input logic corrupt,
                           input logic extra);
    while (cmd_rdy !== 1'b1) begin
      @(negedge clk);
    end
    exp_tx_q.push_back(cmd[15:8]);
    if (cmd[uart_cmd_pkg::rd_bit]) begin
      corrupt_q.push_back(corrupt);
      read_q.push_back({corrupt, cmd[14:8]});
    end else begin
      exp_tx_q.push_back(cmd[7:0]);
    end
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    check_level(cmd_rdy, 1'b0, "cmd_rdy after accept");
    check_level(tx, 1'b1, "tx one cycle after accept");
    @(negedge clk);
    check_level(tx, 1'b0, "start bit two cycles after accept");
    // strobe while busy, must not start anything
    if (extra) begin
      repeat (int'($urandom_range(1, 300))) @(negedge clk);
      check_level(cmd_rdy, 1'b0, "cmd_rdy at ignored strobe");
      cmd_in  = uart_cmd_pkg::cmd_t'($urandom());
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
    end
  endtask

  initial begin : stimulus
    logic                rd;
    logic [6:0]          addr;
    uart_cmd_pkg::byte_t data;
    logic                corrupt;
    logic                extra;
    void'($urandom(29));
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    for (int a = 0; a < 128; a++) begin
      model_mem[a] = '0;
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_level(tx, 1'b1, "tx after reset");
    check_level(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check_level(read_rdy, 1'b0, "read_rdy after reset");

    issue_cmd(16'h05a5, 1'b0, 1'b0);
    issue_cmd(16'h8500, 1'b0, 1'b0);
    // address 0x64 never written
    issue_cmd(16'he400, 1'b0, 1'b0);
    issue_cmd(16'h8500, 1'b1, 1'b0);
    issue_cmd(16'h123c, 1'b0, 1'b1);
    issue_cmd(16'h9200, 1'b0, 1'b1);

    for (int n = 0; n < n_random; n++) begin
      rd      = 1'($urandom_range(0, 1));
      addr    = 7'($urandom_range(0, 127));
      data    = uart_cmd_pkg::byte_t'($urandom_range(0, 255));
      corrupt = rd && ($urandom_range(0, 3) == 0);
      extra   = ($urandom_range(0, 4) == 0);
      issue_cmd({rd, addr, data}, corrupt, extra);
    end

    while (cmd_rdy !== 1'b1) begin
      @(negedge clk);
    end
    repeat (tail_bits * uart_cmd_pkg::clks_per_bit) @(negedge clk);
    if (exp_tx_q.size() != 0 || read_q.size() != 0 || corrupt_q.size() != 0) begin
      $display("%0t: commands still outstanding at the end of the run", $time);
      stop_run();
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

  // remote device on the far end of the serial link
  initial begin : remote_device
    uart_cmd_pkg::byte_t hi;
    uart_cmd_pkg::byte_t lo;
    logic                corrupt;
    int                  wait_cycles;
    wait (rst_n === 1'b1);
    forever begin
      receive_frame(hi);
      if (hi[7]) begin
        corrupt = (corrupt_q.size() != 0) ? corrupt_q.pop_front() : 1'b0;
        // just past the stop bit, then a random gap
        wait_cycles = 2 + int'($urandom_range(0, 20)) * uart_cmd_pkg::clks_per_bit;
        repeat (wait_cycles) @(negedge clk);
        send_reply(model_mem[hi[6:0]], corrupt);
      end else begin
        receive_frame(lo);
        model_mem[hi[6:0]] = lo;
      end
    end
  end

  initial begin : compare_reads
    logic [7:0]                 entry;
    uart_cmd_pkg::read_result_t exp;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (read_rdy === 1'b1) begin
        if (read_q.size() == 0) begin
          $display("%0t: read_rdy pulsed with no read pending", $time);
          stop_run();
        end else begin
          entry = read_q.pop_front();
          exp   = expected_read(entry[6:0], model_mem, entry[7]);
          check_read(read_data, exp);
          @(negedge clk);
          check_level(read_rdy, 1'b0, "read_rdy one cycle wide");
        end
      end
    end
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("%0t: the run timed out waiting for the DUT", $time);
    stop_run();
  end

endmodule

// File: verilog/uart_cmd_bridge.sv
`timescale 1ns/1ns

module uart_cmd_bridge (
  input  logic                       clk,
  input  logic                       rst_n,
  input  uart_cmd_pkg::cmd_t         cmd_in,
  input  logic                       cmd_vld,
  input  logic                       rx,
  output logic                       tx,
  output logic                       cmd_rdy,
  output logic                       read_rdy,
  output uart_cmd_pkg::read_result_t read_data
);

  logic                timer_restart;
  logic                bit_tick;
  logic                mid_tick;
  logic                tx_load;
  uart_cmd_pkg::byte_t tx_byte;
  logic                tx_done;
  logic                rx_arm;
  logic                rx_start;
  logic                rx_valid;
  uart_cmd_pkg::byte_t rx_byte;
  logic                rx_perr;

  baud_timer i_baud_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .restart  (timer_restart),
    .bit_tick (bit_tick),
    .mid_tick (mid_tick)
  );

  uart_tx_frame i_uart_tx_frame (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (tx_load),
    .data     (tx_byte),
    .bit_tick (bit_tick),
    .tx       (tx),
    .done     (tx_done)
  );

  uart_rx_frame i_uart_rx_frame (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .arm      (rx_arm),
    .mid_tick (mid_tick),
    .start    (rx_start),
    .valid    (rx_valid),
    .data     (rx_byte),
    .perr     (rx_perr)
  );

  cmd_fsm i_cmd_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx_load       (tx_load),
    .tx_byte       (tx_byte),
    .tx_done       (tx_done),
    .rx_arm        (rx_arm),
    .rx_start      (rx_start),
    .rx_valid      (rx_valid),
    .rx_byte       (rx_byte),
    .rx_perr       (rx_perr),
    .timer_restart (timer_restart),
    .read_rdy      (read_rdy),
    .read_data     (read_data)
  );

endmodule

// File: verilog/cmd_fsm.sv
`timescale 1ns/1ns

module cmd_fsm (
  input  logic                       clk,
  input  logic                       rst_n,
  input  uart_cmd_pkg::cmd_t         cmd_in,
  input  logic                       cmd_vld,
  output logic                       cmd_rdy,
  output logic                       tx_load,
  output uart_cmd_pkg::byte_t        tx_byte,
  input  logic                       tx_done,
  output logic                       rx_arm,
  input  logic                       rx_start,
  input  logic                       rx_valid,
  input  uart_cmd_pkg::byte_t        rx_byte,
  input  logic                       rx_perr,
  output logic                       timer_restart,
  output logic                       read_rdy,
  output uart_cmd_pkg::read_result_t read_data
);

  typedef enum logic [2:0] {
    st_idle,
    st_send_hi,
    st_send_lo,
    st_wait_reply,
    st_receive
  } state_t;

  state_t             state;
  uart_cmd_pkg::cmd_t cmd_q;
  logic               load_q;
  logic               is_read;
  logic               accept;
  logic               reply_done;

  assign accept     = (state == st_idle) && cmd_vld;
  assign is_read    = cmd_q[uart_cmd_pkg::rd_bit];
  assign reply_done = (state == st_receive) && rx_valid;

  assign cmd_rdy = (state == st_idle);

  // first frame loads one cycle after acceptance, the low byte
  // loads in the same cycle as the first tx_done
  assign tx_load = load_q || ((state == st_send_hi) && tx_done && !is_read);
  assign tx_byte = load_q ? cmd_q[15:8] : cmd_q[7:0];

  // stays armed through receive so a false start can retrigger
  assign rx_arm = (state == st_wait_reply) || (state == st_receive);

  assign timer_restart = tx_load || rx_start;

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reply_done) begin
      read_data <= {rx_perr, rx_byte};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      load_q   <= 1'b0;
      read_rdy <= 1'b0;
    end else begin
      load_q   <= accept;
      read_rdy <= reply_done;
      case (state)
        st_idle: begin
          if (cmd_vld) begin
            state <= st_send_hi;
          end
        end
        st_send_hi: begin
          if (tx_done) begin
            state <= is_read ? st_wait_reply : st_send_lo;
          end
        end
        st_send_lo: begin
          if (tx_done) begin
            state <= st_idle;
          end
        end
        st_wait_reply: begin
          if (rx_start) begin
            state <= st_receive;
          end
        end
        st_receive: begin
          if (rx_valid) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

// File: verilog/uart_rx_frame.sv
`timescale 1ns/1ns

module uart_rx_frame (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx,
  input  logic                arm,
  input  logic                mid_tick,
  output logic                start,
  output logic                valid,
  output uart_cmd_pkg::byte_t data,
  output logic                perr
);

  logic                   rx_s1;
  logic                   rx_s2;
  logic                   rx_prev;
  logic                   busy;
  uart_cmd_pkg::bit_cnt_t bit_cnt;
  // data bits then parity, shifted in from the top
  logic [8:0]             shreg;
  logic                   parity_bad;

  // two flop synchronizer plus one stage for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  assign start = arm && !busy && rx_prev && !rx_s2;

  // odd parity expected over data and parity bit
  assign parity_bad = uart_cmd_pkg::parity_check && !(^shreg);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      valid   <= 1'b0;
    end else begin
      valid <= 1'b0;
      if (start) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end else if (busy && mid_tick) begin
        if (bit_cnt == '0) begin
          // glitch, not a real start bit
          if (rx_s2) begin
            busy <= 1'b0;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end else if (bit_cnt == uart_cmd_pkg::bit_cnt_t'(uart_cmd_pkg::frame_bits - 1)) begin
          busy  <= 1'b0;
          valid <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy && mid_tick && bit_cnt != '0) begin
      if (bit_cnt == uart_cmd_pkg::bit_cnt_t'(uart_cmd_pkg::frame_bits - 1)) begin
        data <= shreg[7:0];
        // stop sample is the live synchronized bit
        perr <= parity_bad || !rx_s2;
      end else begin
        shreg <= {rx_s2, shreg[8:1]};
      end
    end
  end

endmodule

// File: verilog/uart_tx_frame.sv
`timescale 1ns/1ns

module uart_tx_frame (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load,
  input  uart_cmd_pkg::byte_t data,
  input  logic                bit_tick,
  output logic                tx,
  output logic                done
);

  logic                              busy;
  uart_cmd_pkg::bit_cnt_t            bit_cnt;
  logic [uart_cmd_pkg::frame_bits-2:0] shreg;
  logic                              last_bit;

  assign last_bit = (bit_cnt == uart_cmd_pkg::bit_cnt_t'(uart_cmd_pkg::frame_bits - 1));

  // pulses in the final cycle of the stop bit
  assign done = busy && bit_tick && last_bit;

  // remaining bits after the start bit, lsb first
  always_ff @(posedge clk) begin
    if (load) begin
      shreg <= {1'b1, ~^data, data};
    end else if (busy && bit_tick) begin
      shreg <= {1'b1, shreg[uart_cmd_pkg::frame_bits-2:1]};
    end
  end

  // load wins over done so back to back frames have no gap
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx      <= 1'b1;
      busy    <= 1'b0;
      bit_cnt <= '0;
    end else if (load) begin
      tx      <= 1'b0;
      busy    <= 1'b1;
      bit_cnt <= '0;
    end else if (busy && bit_tick) begin
      if (last_bit) begin
        tx   <= 1'b1;
        busy <= 1'b0;
      end else begin
        tx      <= shreg[0];
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

// File: verilog/baud_timer.sv
`timescale 1ns/1ns

module baud_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic restart,
  output logic bit_tick,
  output logic mid_tick
);

  uart_cmd_pkg::baud_cnt_t cnt;

  // free running between frames, realigned on each restart
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (restart || bit_tick) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // last cycle of the bit period
  assign bit_tick = (cnt == uart_cmd_pkg::baud_cnt_t'(uart_cmd_pkg::clks_per_bit - 1));

  // centre of the bit, used for sampling
  assign mid_tick = (cnt == uart_cmd_pkg::baud_cnt_t'(uart_cmd_pkg::clks_per_bit / 2));

endmodule

// File: verilog/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // system clock and line rate
  localparam int clk_freq_hz = 25_000_000;
  localparam int baud_rate   = 115_200;
  localparam int clks_per_bit = clk_freq_hz / baud_rate;

  // start, 8 data, parity, stop
  localparam int frame_bits = 11;

  // 0 leaves the receive error flag at zero
  localparam bit parity_check = 1'b1;

  // read flag position in the command word
  localparam int rd_bit = 15;

  typedef logic [15:0] cmd_t;
  typedef logic [7:0]  byte_t;

  // bit 8 parity error, bits 7..0 received byte
  typedef logic [8:0]  read_result_t;

  // counter types sized from the constants above
  typedef logic [$clog2(clks_per_bit)-1:0] baud_cnt_t;
  typedef logic [$clog2(frame_bits)-1:0]   bit_cnt_t;

endpackage
